// ==== sd_pkg.sv ====
package sd_pkg;

  // Block size is given in bytes
  localparam int unsigned max_block_bit_size = 12;

  // Holds the bit count of a full block plus the 16 CRC cycles
  localparam int unsigned counter_width = max_block_bit_size + 4;

  // Number of blocks in one multi-block read
  localparam int unsigned block_count_width = 8;

  // Receive word FIFO, depth must stay a power of two
  localparam int unsigned fifo_depth = 16;
  localparam int unsigned fifo_addr_width = $clog2(fifo_depth);

  // Receiver states
  typedef enum logic [2:0] {
    idle,
    ready,
    dat,
    crc,
    end_bit
  } dat_rx_state_e;

endpackage

// ==== crc16_read.sv ====
`timescale 1ns/1ns

module crc16_read
  import sd_pkg::*;
(
  input  logic        sd_clk_i,
  input  logic        reset_i,
  input  logic        clear_i,
  input  logic        dat_ser_i,
  output logic [15:0] crc16_o
);

  // CCITT polynomial x^16 + x^12 + x^5 + 1
  localparam logic [15:0] poly = 16'h1021;

  logic [15:0] remainder_q;
  logic [15:0] remainder_d;
  logic        feedback;

  // Data and the received CRC both go through the divider,
  // so a good block leaves nothing behind
  assign feedback = remainder_q[15] ^ dat_ser_i;

  always_comb begin
    remainder_d = {remainder_q[14:0], 1'b0};
    if (feedback) begin
      remainder_d = remainder_d ^ poly;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      remainder_q <= '0;
    end else if (clear_i) begin
      remainder_q <= '0;
    end else begin
      remainder_q <= remainder_d;
    end
  end

  assign crc16_o = remainder_q;

endmodule

// ==== dat_read.sv ====
`timescale 1ns/1ns

module dat_read
  import sd_pkg::*;
(
  input  logic                          sd_clk_i,
  input  logic                          reset_i,
  input  logic [3:0]                    dat_i,
  input  logic                          start_i,
  // Block size in bytes
  input  logic [max_block_bit_size-1:0] block_size_i,
  input  logic                          bus_width_is_4_i,
  output logic                          data_valid_o,
  output logic [31:0]                   data_o,
  output logic                          done_o,
  // Error flags only mean something while done_o is high
  output logic                          crc_err_o,
  output logic                          end_bit_err_o
);

  dat_rx_state_e state_q;
  dat_rx_state_e state_d;

  logic [counter_width-1:0] counter_q;
  logic [counter_width-1:0] counter_d;
  logic [counter_width-1:0] data_cycles;
  logic [counter_width-1:0] last_crc_cycle;

  logic [31:0] buildup_q;
  logic [31:0] buildup_d;
  logic [7:0]  byte_q;
  logic [7:0]  byte_d;
  logic [7:0]  byte_next;
  logic        byte_done;
  logic [1:0]  lane;
  logic        start_bit;

  logic       clear_crc;
  logic [3:0] crc_line_err;

  // Data phase length: 2 cycles per byte on 4 lines, 8 cycles on one
  assign data_cycles = bus_width_is_4_i ? {3'b000, block_size_i, 1'b0}
                                        : {1'b0, block_size_i, 3'b000};
  assign last_crc_cycle = data_cycles + counter_width'(15);

  assign start_bit = bus_width_is_4_i ? (dat_i == 4'b0000) : !dat_i[0];

  // Bytes come in MSB first, a nibble or a bit at a time
  assign byte_next = bus_width_is_4_i ? {byte_q[3:0], dat_i} : {byte_q[6:0], dat_i[0]};
  assign byte_done = bus_width_is_4_i ? counter_q[0] : (counter_q[2:0] == 3'b111);

  // Byte position inside the current word
  assign lane = bus_width_is_4_i ? counter_q[2:1] : counter_q[4:3];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle: begin
        if (start_i) begin
          state_d = ready;
        end
      end
      ready: begin
        if (start_bit) begin
          state_d = dat;
        end
      end
      dat: begin
        if (counter_q + 1'b1 == data_cycles) begin
          state_d = crc;
        end
      end
      crc: begin
        if (counter_q == last_crc_cycle) begin
          state_d = end_bit;
        end
      end
      end_bit: state_d = idle;
      default: state_d = idle;
    endcase
  end

  always_comb begin
    counter_d     = counter_q;
    buildup_d     = buildup_q;
    byte_d        = byte_q;
    clear_crc     = 1'b0;
    data_valid_o  = 1'b0;
    data_o        = '0;
    done_o        = 1'b0;
    crc_err_o     = 1'b0;
    end_bit_err_o = 1'b0;

    unique case (state_q)
      ready: begin
        // Keep the CRC cleared until the start bit has passed
        counter_d = '0;
        buildup_d = '0;
        clear_crc = 1'b1;
      end
      dat: begin
        counter_d = counter_q + 1'b1;
        byte_d    = byte_next;
        if (byte_done) begin
          if (lane == 2'd3) begin
            // Last byte of the word goes straight out with the rest
            data_valid_o = 1'b1;
            data_o       = {byte_next, buildup_q[23:0]};
            buildup_d    = '0;
          end else begin
            buildup_d[{lane, 3'b000} +: 8] = byte_next;
          end
        end
      end
      crc: begin
        counter_d = counter_q + 1'b1;
        // Partial word, upper bytes are still zero from the last clear
        if (counter_q == data_cycles && block_size_i[1:0] != 2'b00) begin
          data_valid_o = 1'b1;
          data_o       = buildup_q;
          buildup_d    = '0;
        end
      end
      end_bit: begin
        done_o        = 1'b1;
        crc_err_o     = bus_width_is_4_i ? |crc_line_err : crc_line_err[0];
        end_bit_err_o = bus_width_is_4_i ? (dat_i != 4'b1111) : !dat_i[0];
      end
      default: ;
    endcase
  end

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      state_q   <= idle;
      counter_q <= '0;
    end else begin
      state_q   <= state_d;
      counter_q <= counter_d;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    buildup_q <= buildup_d;
    byte_q    <= byte_d;
  end

  // One checker per line; unused lines in 1-bit mode are ignored
  for (genvar i = 0; i < 4; i++) begin : g_crc_line
    logic [15:0] remainder;

    crc16_read crc16_read_inst (
      .sd_clk_i  (sd_clk_i),
      .reset_i   (reset_i),
      .clear_i   (clear_crc),
      .dat_ser_i (dat_i[i]),
      .crc16_o   (remainder)
    );

    assign crc_line_err[i] = (remainder != 16'h0000);
  end

  a_valid_in_data_phase: assert property (
    @(posedge sd_clk_i) disable iff (reset_i)
    data_valid_o |-> (state_q inside {dat, crc})
  );

  a_done_single_cycle: assert property (
    @(posedge sd_clk_i) disable iff (reset_i)
    done_o |=> !done_o
  );

endmodule

// ==== multi_block_read.sv ====
`timescale 1ns/1ns

module multi_block_read
  import sd_pkg::*;
(
  input  logic                         sd_clk_i,
  input  logic                         reset_i,
  input  logic                         start_i,
  input  logic [block_count_width-1:0] block_count_i,
  input  logic                         blk_done_i,
  input  logic                         blk_crc_err_i,
  input  logic                         blk_end_bit_err_i,
  output logic                         blk_start_o,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         crc_err_o,
  output logic                         end_bit_err_o
);

  logic [block_count_width-1:0] remaining_q;
  logic                         last_block;
  logic                         blk_start_q;
  logic                         busy_q;
  logic                         done_q;
  logic                         crc_err_q;
  logic                         end_bit_err_q;

  assign last_block = (remaining_q == block_count_width'(1));

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      remaining_q <= '0;
      blk_start_q <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      blk_start_q <= 1'b0;
      done_q      <= 1'b0;
      if (start_i) begin
        remaining_q <= block_count_i;
        blk_start_q <= 1'b1;
        busy_q      <= 1'b1;
      end else if (blk_done_i) begin
        remaining_q <= remaining_q - 1'b1;
        // Errors do not stop the read, every block is received
        if (last_block) begin
          done_q <= 1'b1;
        end else begin
          blk_start_q <= 1'b1;
        end
      end else if (done_q) begin
        // Busy covers the done cycle and drops right after
        busy_q <= 1'b0;
      end
    end
  end

  // Sticky over the whole read
  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      crc_err_q     <= 1'b0;
      end_bit_err_q <= 1'b0;
    end else if (start_i) begin
      crc_err_q     <= 1'b0;
      end_bit_err_q <= 1'b0;
    end else if (blk_done_i) begin
      crc_err_q     <= crc_err_q | blk_crc_err_i;
      end_bit_err_q <= end_bit_err_q | blk_end_bit_err_i;
    end
  end

  assign blk_start_o   = blk_start_q;
  assign busy_o        = busy_q;
  assign done_o        = done_q;
  assign crc_err_o     = crc_err_q;
  assign end_bit_err_o = end_bit_err_q;

  a_blk_done_while_busy: assert property (
    @(posedge sd_clk_i) disable iff (reset_i)
    blk_done_i |-> busy_o
  );

endmodule

// ==== rx_word_fifo.sv ====
`timescale 1ns/1ns

module rx_word_fifo
  import sd_pkg::*;
(
  input  logic        sd_clk_i,
  input  logic        reset_i,
  input  logic        clear_i,
  input  logic        push_i,
  input  logic [31:0] push_data_i,
  input  logic        pop_i,
  output logic [31:0] pop_data_o,
  output logic        valid_o,
  output logic        overflow_o
);

  logic [31:0] mem [fifo_depth];

  logic [fifo_addr_width-1:0] wr_ptr_q;
  logic [fifo_addr_width-1:0] rd_ptr_q;
  logic [fifo_addr_width:0]   count_q;
  logic                       overflow_q;
  logic                       full;
  logic                       do_push;
  logic                       do_pop;

  // Depth is a power of two, so the top count bit means full
  assign full = count_q[fifo_addr_width];

  // A pop in the same cycle frees the slot for a push on a full FIFO
  assign do_pop  = pop_i && valid_o;
  assign do_push = push_i && (!full || do_pop);

  always_ff @(posedge sd_clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // The card cannot wait, the word is lost
      if (push_i && !do_push) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem[rd_ptr_q];
  assign valid_o    = (count_q != '0);
  assign overflow_o = overflow_q;

  a_pop_only_when_valid: assert property (
    @(posedge sd_clk_i) disable iff (reset_i)
    pop_i |-> valid_o
  );

endmodule

// ==== sd_read_top.sv ====
`timescale 1ns/1ns

module sd_read_top
  import sd_pkg::*;
(
  input  logic                          sd_clk_i,
  input  logic                          reset_i,
  // Card side, lines idle high
  input  logic [3:0]                    dat_i,
  // Host control, held stable for the whole read
  input  logic                          start_i,
  input  logic [block_count_width-1:0]  block_count_i,
  input  logic [max_block_bit_size-1:0] block_size_i,
  input  logic                          bus_width_is_4_i,
  // Host status
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          crc_err_o,
  output logic                          end_bit_err_o,
  // Received words
  output logic                          word_valid_o,
  output logic [31:0]                   word_o,
  input  logic                          word_pop_i,
  output logic                          overflow_o
);

  logic        blk_start;
  logic        blk_done;
  logic        blk_crc_err;
  logic        blk_end_bit_err;
  logic        data_valid;
  logic [31:0] data;

  multi_block_read multi_block_read_inst (
    .sd_clk_i          (sd_clk_i),
    .reset_i           (reset_i),
    .start_i           (start_i),
    .block_count_i     (block_count_i),
    .blk_done_i        (blk_done),
    .blk_crc_err_i     (blk_crc_err),
    .blk_end_bit_err_i (blk_end_bit_err),
    .blk_start_o       (blk_start),
    .busy_o            (busy_o),
    .done_o            (done_o),
    .crc_err_o         (crc_err_o),
    .end_bit_err_o     (end_bit_err_o)
  );

  dat_read dat_read_inst (
    .sd_clk_i         (sd_clk_i),
    .reset_i          (reset_i),
    .dat_i            (dat_i),
    .start_i          (blk_start),
    .block_size_i     (block_size_i),
    .bus_width_is_4_i (bus_width_is_4_i),
    .data_valid_o     (data_valid),
    .data_o           (data),
    .done_o           (blk_done),
    .crc_err_o        (blk_crc_err),
    .end_bit_err_o    (blk_end_bit_err)
  );

  // A new read also flushes leftover words and the overflow flag
  rx_word_fifo rx_word_fifo_inst (
    .sd_clk_i    (sd_clk_i),
    .reset_i     (reset_i),
    .clear_i     (start_i),
    .push_i      (data_valid),
    .push_data_i (data),
    .pop_i       (word_pop_i),
    .pop_data_o  (word_o),
    .valid_o     (word_valid_o),
    .overflow_o  (overflow_o)
  );

endmodule

// ==== tb_sd_card.sv ====
`timescale 1ns/1ns

module tb_sd_card (
  input  logic       sd_clk_i,
  output logic [3:0] dat_o
);

  // Running CRC of each DAT line over the current block
  logic [15:0] line_crc [4];

  initial begin
    dat_o = 4'hf;
  end

  // CCITT CRC-16, one bit per call, MSB first
  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic bit_in);
    logic feedback;
    feedback = crc[15] ^ bit_in;
    return {crc[14:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
  endfunction

  task automatic drive_cycle(input logic [3:0] lines);
    @(posedge sd_clk_i);
    dat_o <= lines;
    for (int i = 0; i < 4; i++) begin
      line_crc[i] = crc16_next(line_crc[i], lines[i]);
    end
  endtask

  // Sends count blocks of size bytes each, taken in order from bytes
  task automatic send_read(input logic [7:0] bytes [$], input bit width4, input int size,
                           input int count, input logic [31:0] gap_bits, input int flip_blk,
                           input int low_end_blk);
    logic [15:0] sent [4];
    logic [7:0]  data_byte;
    logic [3:0]  end_lines;
    for (int blk = 0; blk < count; blk++) begin
      // Idle gap of 2 to 9 cycles before the start bit
      repeat (2 + int'(gap_bits[3*blk +: 3])) begin
        drive_cycle(4'hf);
      end
      drive_cycle(width4 ? 4'h0 : 4'he);
      for (int i = 0; i < 4; i++) begin
        line_crc[i] = '0;
      end
      for (int k = 0; k < size; k++) begin
        data_byte = bytes[blk*size + k];
        if (width4) begin
          drive_cycle(data_byte[7:4]);
          drive_cycle(data_byte[3:0]);
        end else begin
          for (int j = 7; j >= 0; j--) begin
            drive_cycle({3'b111, data_byte[j]});
          end
        end
      end
      sent = line_crc;
      if (blk == flip_blk) begin
        sent[0][6] = ~sent[0][6];
      end
      for (int j = 15; j >= 0; j--) begin
        if (width4) begin
          drive_cycle({sent[3][j], sent[2][j], sent[1][j], sent[0][j]});
        end else begin
          drive_cycle({3'b111, sent[0][j]});
        end
      end
      end_lines = 4'hf;
      if (blk == low_end_blk) begin
        end_lines[0] = 1'b0;
      end
      drive_cycle(end_lines);
    end
    drive_cycle(4'hf);
  endtask

endmodule

// ==== tb_sd_read.sv ====
`timescale 1ns/1ns

module tb_sd_read
  import sd_pkg::*;
();

  logic                          sd_clk_i;
  logic                          reset_i;
  logic [3:0]                    dat_i;
  logic                          start_i;
  logic [block_count_width-1:0]  block_count_i;
  logic [max_block_bit_size-1:0] block_size_i;
  logic                          bus_width_is_4_i;
  logic                          busy_o;
  logic                          done_o;
  logic                          crc_err_o;
  logic                          end_bit_err_o;
  logic                          word_valid_o;
  logic [31:0]                   word_o;
  logic                          word_pop_i;
  logic                          overflow_o;

  logic [31:0] lfsr_q;
  logic [31:0] expected_word;
  logic [31:0] expected_q [$];
  logic [7:0]  data_q [$];
  string       test_name;
  int          checks;
  int          errors;
  int          popped;
  int          done_count;
  bit          check_enable;
  bit          timed_out;

  always #10 sd_clk_i = ~sd_clk_i;

  sd_read_top sd_read_top_inst (.*);

  tb_sd_card tb_sd_card_inst (
    .sd_clk_i (sd_clk_i),
    .dat_o    (dat_i)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  // First byte of a word lands in bits 7:0
  // Short last word of a block is padded with zeros
  function automatic void build_expected(input logic [7:0] bytes [$], input int size,
                                         input int count);
    logic [31:0] packed_word;
    for (int blk = 0; blk < count; blk++) begin
      for (int k = 0; k < size; k += 4) begin
        packed_word = '0;
        for (int j = 0; j < 4; j++) begin
          if (k + j < size) begin
            packed_word[8*j +: 8] = bytes[blk*size + k + j];
          end
        end
        expected_q.push_back(packed_word);
      end
    end
  endfunction

  task automatic compare_value(input string what, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch in %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  // Word checker
  // A pop takes effect on the edge after it is raised
  always @(posedge sd_clk_i) begin
    if (done_o) begin
      done_count++;
    end
    if (word_pop_i) begin
      word_pop_i <= 1'b0;
      popped++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("error in %s: popped a word that no block should have produced", test_name);
      end else begin
        expected_word = expected_q.pop_front();
        checks++;
        if (word_o !== expected_word) begin
          errors++;
          $display("mismatch in %s, word: expected %h, actual %h",
                   test_name, expected_word, word_o);
        end
      end
    end else if (check_enable && word_valid_o) begin
      word_pop_i <= 1'b1;
    end
  end

  task automatic wait_done(input int limit);
    int cycles;
    bit got_done;
    bit busy_low;
    cycles   = 0;
    got_done = 1'b0;
    busy_low = 1'b0;
    while (!got_done && cycles < limit) begin
      @(posedge sd_clk_i);
      cycles++;
      got_done = done_o;
      if (!busy_o && !busy_low) begin
        busy_low = 1'b1;
        errors++;
        $display("error in %s: busy_o went low before done_o", test_name);
      end
    end
    if (!got_done) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout in %s: done_o did not come within %0d cycles", test_name, limit);
    end
  endtask

  task automatic drain_words(input int limit);
    int cycles;
    cycles = 0;
    while ((word_valid_o || word_pop_i) && cycles < limit) begin
      @(posedge sd_clk_i);
      cycles++;
    end
    if (word_valid_o || word_pop_i) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout in %s: FIFO still holds words after %0d cycles", test_name, limit);
    end
  endtask

  task automatic run_read(input string name, input bit width4, input int size, input int count,
                          input int flip_blk, input int low_end_blk, input bit hold_checker);
    logic [31:0] rand_word;
    logic [31:0] gap_bits;
    int          total_words;
    int          popped_before;
    if (timed_out) begin
      return;
    end
    test_name = name;
    data_q.delete();
    expected_q.delete();
    for (int i = 0; i < size * count; i++) begin
      take_bits(8, rand_word);
      data_q.push_back(rand_word[7:0]);
    end
    take_bits(3 * count, gap_bits);
    build_expected(data_q, size, count);
    total_words   = expected_q.size();
    popped_before = popped;
    check_enable  = !hold_checker;
    done_count    = 0;
    @(posedge sd_clk_i);
    start_i          <= 1'b1;
    block_count_i    <= block_count_width'(count);
    block_size_i     <= max_block_bit_size'(size);
    bus_width_is_4_i <= width4;
    @(posedge sd_clk_i);
    start_i <= 1'b0;
    fork
      tb_sd_card_inst.send_read(data_q, width4, size, count, gap_bits, flip_blk, low_end_blk);
      wait_done(20000);
    join
    if (timed_out) begin
      return;
    end
    if (hold_checker) begin
      compare_value("overflow_o", 1, int'(overflow_o));
      check_enable = 1'b1;
    end
    drain_words(200);
    // Busy ends with the done cycle
    @(posedge sd_clk_i);
    compare_value("busy_o after done_o", 0, int'(busy_o));
    compare_value("crc_err_o", int'(flip_blk >= 0), int'(crc_err_o));
    compare_value("end_bit_err_o", int'(low_end_blk >= 0), int'(end_bit_err_o));
    compare_value("done_o pulses", 1, done_count);
    if (hold_checker) begin
      compare_value("words popped", fifo_depth, popped - popped_before);
      expected_q.delete();
    end else begin
      compare_value("overflow_o", 0, int'(overflow_o));
      compare_value("words popped", total_words, popped - popped_before);
    end
  endtask

  initial begin
    sd_clk_i         = 1'b0;
    reset_i          = 1'b1;
    start_i          = 1'b0;
    block_count_i    = '0;
    block_size_i     = '0;
    bus_width_is_4_i = 1'b0;
    word_pop_i       = 1'b0;
    lfsr_q           = 32'h123e2870;
    checks           = 0;
    errors           = 0;
    popped           = 0;
    done_count       = 0;
    check_enable     = 1'b1;
    timed_out        = 1'b0;
    repeat (8) @(posedge sd_clk_i);
    reset_i <= 1'b0;

    run_read("four_bit_512", 1'b1, 512, 1, -1, -1, 1'b0);
    run_read("one_bit_64", 1'b0, 64, 1, -1, -1, 1'b0);
    for (int size = 5; size <= 7; size++) begin
      run_read($sformatf("four_bit_partial_%0d", size), 1'b1, size, 1, -1, -1, 1'b0);
      run_read($sformatf("one_bit_partial_%0d", size), 1'b0, size, 1, -1, -1, 1'b0);
    end
    run_read("four_bit_3x32", 1'b1, 32, 3, -1, -1, 1'b0);
    // CRC bit flipped in the second block only
    run_read("crc_flip_block_1", 1'b1, 32, 3, 1, -1, 1'b0);
    run_read("end_bit_low", 1'b1, 16, 2, -1, 0, 1'b0);
    run_read("overflow", 1'b1, 128, 1, -1, -1, 1'b1);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
sd_pkg.sv
crc16_read.sv
dat_read.sv
multi_block_read.sv
rx_word_fifo.sv
sd_read_top.sv
tb_sd_card.sv
tb_sd_read.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the SD read testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_sd_read \
    -f vlog.f -o sim_sd_read; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/sim_sd_read > sim.log 2>&1; then
  cat sim.log
  echo "Simulation ended with an error status"
  exit 1
fi
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
exit 0
